/* common/pitch_pkg.sv */
`default_nettype none

package pitch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	localparam int SAMPLE_W = 16;
	localparam int ACC_W    = 32;
	localparam int LAG_W    = 8;

	// Address field of the test write port
	localparam int WR_AW    = 8;

	// Q31 saturation limits
	localparam logic [ACC_W-1:0] ACC_MAX = 32'h7fff_ffff;
	localparam logic [ACC_W-1:0] ACC_MIN = 32'h8000_0000;

	// Sequencer states
	typedef enum logic [1:0]
	{
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,
		ST_DRAIN = 2'd2,
		ST_DONE  = 2'd3
	} ctrl_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles between blocks
	////////////////////////////////////////////////////////////////////////////

	// Scratch memory write request
	typedef struct packed
	{
		logic                en;
		logic [WR_AW-1:0]    addr;
		logic [SAMPLE_W-1:0] data;
	} mem_wr_t;

	// One correlation step for a lane
	typedef struct packed
	{
		logic                valid;
		logic                clear;
		logic                last;
		logic [SAMPLE_W-1:0] x;
		logic [SAMPLE_W-1:0] e;
	} lane_in_t;

	// Finished correlation of one lag
	typedef struct packed
	{
		logic             valid;
		logic [ACC_W-1:0] corr;
	} lane_out_t;

	// Lag with its correlation, offered to the selector
	typedef struct packed
	{
		logic             valid;
		logic [LAG_W-1:0] lag;
		logic [ACC_W-1:0] corr;
	} cand_t;

endpackage

`default_nettype wire

/* verilog/scratch_mem.sv */
`default_nettype none
`timescale 1ns/100ps

module scratch_mem #(
	parameter int ADDR_W = 8
)(
	input  logic                             i_clock,
	input  logic                             i_test_mode,
	input  pitch_pkg::mem_wr_t               i_wr,
	input  logic [ADDR_W-1:0]                i_rd_addr0,
	input  logic [ADDR_W-1:0]                i_rd_addr1,
	input  logic [ADDR_W-1:0]                i_rd_addr2,
	input  logic [ADDR_W-1:0]                i_test_rd_addr,
	output logic [pitch_pkg::SAMPLE_W-1:0]   o_rd_data0,
	output logic [pitch_pkg::SAMPLE_W-1:0]   o_rd_data1,
	output logic [pitch_pkg::SAMPLE_W-1:0]   o_rd_data2
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [pitch_pkg::SAMPLE_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0]              rd_addr0;

	// Port 0 is shared with the test readback path
	assign rd_addr0 = i_test_mode ? i_test_rd_addr : i_rd_addr0;

	// Only the test port writes, and only in test mode
	always_ff @(posedge i_clock)
	begin
		if (i_test_mode && i_wr.en)
		begin
			mem[ADDR_W'(i_wr.addr)] <= i_wr.data;
		end
	end

	// Three synchronous read ports, data one cycle after the address
	always_ff @(posedge i_clock)
	begin
		o_rd_data0 <= mem[rd_addr0];
		o_rd_data1 <= mem[i_rd_addr1];
		o_rd_data2 <= mem[i_rd_addr2];
	end

endmodule

`default_nettype wire

/* lag_search/lag_search_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module lag_search_ctrl #(
	parameter int L_SUBFR  = 40,
	parameter int PIT_MAX  = 143,
	parameter int EXC_BASE = 64,
	parameter int ADDR_W   = 8
)(
	input  logic                          i_clock,
	input  logic                          i_rst_n,
	input  logic                          i_start,
	input  logic                          i_test_mode,
	input  logic [pitch_pkg::LAG_W-1:0]   i_t_min,
	input  logic [pitch_pkg::LAG_W-1:0]   i_t_max,
	output logic [ADDR_W-1:0]             o_x_addr,
	output logic [ADDR_W-1:0]             o_ea_addr,
	output logic [ADDR_W-1:0]             o_eb_addr,
	output logic                          o_valid_a,
	output logic                          o_valid_b,
	output logic                          o_clear,
	output logic                          o_last,
	output logic                          o_done,
	output logic [pitch_pkg::LAG_W-1:0]   o_lag
);

	localparam int N_W          = $clog2(L_SUBFR);
	localparam int EXC_ORG      = EXC_BASE + PIT_MAX;
	localparam int DRAIN_CYCLES = 3;
	localparam int LW           = pitch_pkg::LAG_W;

	pitch_pkg::ctrl_state_t state;

	logic [N_W-1:0] n_cnt;
	logic [LW-1:0]  lag;
	logic [LW-1:0]  t_max_q;
	logic [LW-1:0]  lag_d1;
	logic [LW:0]    lag_step;
	logic           start_ok;
	logic           pair_end;
	logic           range_end;
	logic           iss_valid;
	logic           iss_valid_b;

	assign start_ok  = (state == pitch_pkg::ST_IDLE) && i_start && !i_test_mode;
	assign iss_valid = (state == pitch_pkg::ST_RUN);
	assign pair_end  = (n_cnt == N_W'(L_SUBFR - 1));
	assign lag_step  = {1'b0, lag} + (LW+1)'(2);
	// Next pair would start above the range
	assign range_end = (lag_step > {1'b0, t_max_q});
	// Odd lag of the pair only while T+1 stays inside the range
	assign iss_valid_b = iss_valid && (lag < t_max_q);

	// Address triple for x[n], exc[n-T] and exc[n-T-1]
	assign o_x_addr  = ADDR_W'(n_cnt);
	assign o_ea_addr = ADDR_W'(EXC_ORG + int'(n_cnt) - int'(lag));
	assign o_eb_addr = ADDR_W'(EXC_ORG + int'(n_cnt) - int'(lag) - 1);

	assign o_done = (state == pitch_pkg::ST_DONE);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			state   <= pitch_pkg::ST_IDLE;
			n_cnt   <= '0;
			lag     <= '0;
			t_max_q <= '0;
		end
		else
		begin
			case (state)
				pitch_pkg::ST_IDLE:
				begin
					if (start_ok)
					begin
						state   <= pitch_pkg::ST_RUN;
						n_cnt   <= '0;
						lag     <= i_t_min;
						t_max_q <= i_t_max;
					end
				end
				pitch_pkg::ST_RUN:
				begin
					if (pair_end)
					begin
						n_cnt <= '0;
						if (range_end)
							state <= pitch_pkg::ST_DRAIN;
						else
							lag <= lag_step[LW-1:0];
					end
					else
						n_cnt <= n_cnt + 1'b1;
				end
				// n_cnt counts the drain cycles here
				pitch_pkg::ST_DRAIN:
				begin
					if (n_cnt == N_W'(DRAIN_CYCLES - 1))
					begin
						n_cnt <= '0;
						state <= pitch_pkg::ST_DONE;
					end
					else
						n_cnt <= n_cnt + 1'b1;
				end
				pitch_pkg::ST_DONE:
					state <= pitch_pkg::ST_IDLE;
				default:
					state <= pitch_pkg::ST_IDLE;
			endcase
		end
	end

	// Strobes lined up with the memory read data
	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			o_valid_a <= 1'b0;
			o_valid_b <= 1'b0;
			o_clear   <= 1'b0;
			o_last    <= 1'b0;
		end
		else
		begin
			o_valid_a <= iss_valid;
			o_valid_b <= iss_valid_b;
			o_clear   <= iss_valid && (n_cnt == '0);
			o_last    <= iss_valid && pair_end;
		end
	end

	// Lag follows the pair down to the lane result
	always_ff @(posedge i_clock)
	begin
		lag_d1 <= lag;
		o_lag  <= lag_d1;
	end

	a_lag_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		start_ok |-> (i_t_min <= i_t_max) && (int'(i_t_max) <= PIT_MAX))
		else $error("lag range at start is out of order or above PIT_MAX");

endmodule

`default_nettype wire

/* lag_search/corr_lane.sv */
`default_nettype none
`timescale 1ns/100ps

module corr_lane (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  pitch_pkg::lane_in_t  i_cmd,
	output pitch_pkg::lane_out_t o_res
);

	localparam int AW = pitch_pkg::ACC_W;

	logic signed [AW-1:0] raw_prod;
	logic [AW-1:0]        product;
	logic [AW-1:0]        acc;
	logic [AW-1:0]        acc_in;
	logic [AW:0]          sum_wide;
	logic [AW-1:0]        sum_sat;
	logic                 res_valid;
	logic [AW-1:0]        res_corr;
	logic                 both_min;

	assign raw_prod = $signed(i_cmd.x) * $signed(i_cmd.e);
	assign both_min = (i_cmd.x == 16'h8000) && (i_cmd.e == 16'h8000);

	// L_mult, the doubled product saturates only for -1 * -1
	assign product = both_min ? pitch_pkg::ACC_MAX : {raw_prod[AW-2:0], 1'b0};

	// First sample of a lag starts from zero
	assign acc_in = i_cmd.clear ? '0 : acc;

	// L_add with one guard bit
	assign sum_wide = {acc_in[AW-1], acc_in} + {product[AW-1], product};

	always_comb
	begin
		if (sum_wide[AW] != sum_wide[AW-1])
			sum_sat = sum_wide[AW] ? pitch_pkg::ACC_MIN : pitch_pkg::ACC_MAX;
		else
			sum_sat = sum_wide[AW-1:0];
	end

	always_ff @(posedge i_clock)
	begin
		if (i_cmd.valid)
			acc <= sum_sat;
		if (i_cmd.valid && i_cmd.last)
			res_corr <= sum_sat;
	end

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= i_cmd.valid && i_cmd.last;
	end

	assign o_res = {res_valid, res_corr};

	// Top must qualify the shared clear with the lane's own valid
	a_clear_valid: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_cmd.clear |-> i_cmd.valid)
		else $error("lane clear without valid");

endmodule

`default_nettype wire

/* lag_search/lag_select.sv */
`default_nettype none
`timescale 1ns/100ps

module lag_select (
	input  logic                          i_clock,
	input  logic                          i_rst_n,
	input  logic                          i_start,
	input  pitch_pkg::cand_t              i_cand_a,
	input  pitch_pkg::cand_t              i_cand_b,
	output logic [pitch_pkg::LAG_W-1:0]   o_best_lag,
	output logic [pitch_pkg::ACC_W-1:0]   o_best_corr,
	output logic                          o_best_valid
);

	logic                          take_a;
	logic                          take_b;
	logic                          mid_valid;
	logic [pitch_pkg::LAG_W-1:0]   mid_lag;
	logic [pitch_pkg::ACC_W-1:0]   mid_corr;
	logic [pitch_pkg::LAG_W-1:0]   nxt_lag;
	logic [pitch_pkg::ACC_W-1:0]   nxt_corr;

	// Lane A first, then B against that result
	// Strict compare keeps the smaller lag on a tie
	always_comb
	begin
		take_a = i_cand_a.valid &&
			(!o_best_valid || ($signed(i_cand_a.corr) > $signed(o_best_corr)));
		mid_valid = o_best_valid || i_cand_a.valid;
		mid_lag   = take_a ? i_cand_a.lag : o_best_lag;
		mid_corr  = take_a ? i_cand_a.corr : o_best_corr;

		take_b = i_cand_b.valid &&
			(!mid_valid || ($signed(i_cand_b.corr) > $signed(mid_corr)));
		nxt_lag  = take_b ? i_cand_b.lag : mid_lag;
		nxt_corr = take_b ? i_cand_b.corr : mid_corr;
	end

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			o_best_valid <= 1'b0;
			o_best_lag   <= '0;
			o_best_corr  <= '0;
		end
		else if (i_start)
		begin
			o_best_valid <= 1'b0;
			o_best_lag   <= '0;
			o_best_corr  <= '0;
		end
		else if (take_a || take_b)
		begin
			o_best_valid <= 1'b1;
			o_best_lag   <= nxt_lag;
			o_best_corr  <= nxt_corr;
		end
	end

endmodule

`default_nettype wire

/* verilog/pitch_search_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pitch_search_top #(
	parameter int L_SUBFR  = 40,
	parameter int PIT_MAX  = 143,
	parameter int EXC_BASE = 64,
	parameter int ADDR_W   = 8
)(
	input  logic                              i_clock,
	input  logic                              i_rst_n,
	input  logic                              i_start,
	input  logic                              i_test_mode,
	input  pitch_pkg::mem_wr_t                i_test_wr,
	input  logic [ADDR_W-1:0]                 i_test_rd_addr,
	input  logic [pitch_pkg::LAG_W-1:0]       i_t_min,
	input  logic [pitch_pkg::LAG_W-1:0]       i_t_max,
	output logic [pitch_pkg::SAMPLE_W-1:0]    o_test_rd_data,
	output logic                              o_done,
	output logic [pitch_pkg::LAG_W-1:0]       o_best_lag,
	output logic [pitch_pkg::ACC_W-1:0]       o_best_corr
);

	logic [ADDR_W-1:0]                x_addr;
	logic [ADDR_W-1:0]                ea_addr;
	logic [ADDR_W-1:0]                eb_addr;
	logic [pitch_pkg::SAMPLE_W-1:0]   rd_x;
	logic [pitch_pkg::SAMPLE_W-1:0]   rd_ea;
	logic [pitch_pkg::SAMPLE_W-1:0]   rd_eb;
	logic                             valid_a;
	logic                             valid_b;
	logic                             clear;
	logic                             last;
	logic [pitch_pkg::LAG_W-1:0]      ctrl_lag;
	logic                             best_valid;
	logic                             run_busy;
	logic                             sel_start;
	pitch_pkg::lane_in_t              cmd_a;
	pitch_pkg::lane_in_t              cmd_b;
	pitch_pkg::lane_out_t             res_a;
	pitch_pkg::lane_out_t             res_b;
	pitch_pkg::cand_t                 cand_a;
	pitch_pkg::cand_t                 cand_b;

	// Port 0 doubles as the test readback
	assign o_test_rd_data = rd_x;

	scratch_mem #(.ADDR_W(ADDR_W)) mem0 (
		.i_clock        (i_clock),
		.i_test_mode    (i_test_mode),
		.i_wr           (i_test_wr),
		.i_rd_addr0     (x_addr),
		.i_rd_addr1     (ea_addr),
		.i_rd_addr2     (eb_addr),
		.i_test_rd_addr (i_test_rd_addr),
		.o_rd_data0     (rd_x),
		.o_rd_data1     (rd_ea),
		.o_rd_data2     (rd_eb)
	);

	lag_search_ctrl #(
		.L_SUBFR  (L_SUBFR),
		.PIT_MAX  (PIT_MAX),
		.EXC_BASE (EXC_BASE),
		.ADDR_W   (ADDR_W)
	) ctrl0 (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_test_mode (i_test_mode),
		.i_t_min     (i_t_min),
		.i_t_max     (i_t_max),
		.o_x_addr    (x_addr),
		.o_ea_addr   (ea_addr),
		.o_eb_addr   (eb_addr),
		.o_valid_a   (valid_a),
		.o_valid_b   (valid_b),
		.o_clear     (clear),
		.o_last      (last),
		.o_done      (o_done),
		.o_lag       (ctrl_lag)
	);

	////////////////////////////////////////////////////////////////////////////
	// Lanes, even offset on A and odd offset on B
	////////////////////////////////////////////////////////////////////////////

	assign cmd_a = '{valid: valid_a, clear: clear, last: last, x: rd_x, e: rd_ea};
	assign cmd_b = '{valid: valid_b, clear: clear & valid_b, last: last & valid_b,
		x: rd_x, e: rd_eb};

	corr_lane lane_a0 (.i_clock(i_clock), .i_rst_n(i_rst_n), .i_cmd(cmd_a), .o_res(res_a));
	corr_lane lane_b0 (.i_clock(i_clock), .i_rst_n(i_rst_n), .i_cmd(cmd_b), .o_res(res_b));

	assign cand_a = '{valid: res_a.valid, lag: ctrl_lag, corr: res_a.corr};
	assign cand_b = '{valid: res_b.valid, lag: ctrl_lag + 8'd1, corr: res_b.corr};

	// Same acceptance rule as the sequencer, so a start mid-run keeps the best
	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			run_busy <= 1'b0;
		else if (o_done)
			run_busy <= 1'b0;
		else if (sel_start)
			run_busy <= 1'b1;
	end

	assign sel_start = i_start && !run_busy && !i_test_mode;

	lag_select sel0 (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_start      (sel_start),
		.i_cand_a     (cand_a),
		.i_cand_b     (cand_b),
		.o_best_lag   (o_best_lag),
		.o_best_corr  (o_best_corr),
		.o_best_valid (best_valid)
	);

	// Every run produces at least one lag before done
	a_done_best: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_done |-> best_valid)
		else $error("done without a valid best lag");

endmodule

`default_nettype wire

/* tests/pitch_search_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module pitch_search_checker #(
	parameter int DONE_SLACK = 16
)(
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic [7:0]  i_t_min,
	input  logic [7:0]  i_t_max,
	input  logic        i_done,
	input  logic [15:0] i_test_rd_data,
	input  logic [7:0]  i_best_lag,
	input  logic [31:0] i_best_corr,
	input  logic        i_rd_check,
	input  logic [15:0] i_rd_exp,
	input  logic        i_arm,
	input  int          i_test_num,
	input  int          i_exp_cycles,
	input  logic [7:0]  i_exp_lag,
	input  logic [31:0] i_exp_corr,
	output int          o_finished,
	output int          o_passed,
	output int          o_errors
);

	int          finished = 0;
	int          passed = 0;
	int          errors = 0;
	int          errors_mark = 0;
	int          cycles = 0;
	logic        active = 1'b0;
	int          test_num = 0;
	int          exp_cycles = 0;
	logic [7:0]  exp_lag = '0;
	logic [31:0] exp_corr = '0;
	logic [7:0]  t_lo = '0;
	logic [7:0]  t_hi = '0;

	assign o_finished = finished;
	assign o_passed   = passed;
	assign o_errors   = errors;

	task automatic word_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("Fail %0t %s expected 0x%h got 0x%h", $time, name, exp, got);
		errors++;
	endtask

	task automatic number_mismatch(input string name, input int exp, input int got);
		$display("Fail %0t %s expected %0d got %0d", $time, name, exp, got);
		errors++;
	endtask

	// One summary line per run, errors counted since the last one
	task automatic close_test();
		int test_errs;
		test_errs = errors - errors_mark;
		errors_mark = errors;
		finished++;
		if (test_errs == 0)
			passed++;
		$display("test %0d lags %0d..%0d: lag %0d corr 0x%h after %0d cycles, %s",
			test_num, t_lo, t_hi, i_best_lag, i_best_corr, cycles,
			(test_errs == 0) ? "pass" : "fail");
		active = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Readback, latency and result compare
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clock)
	begin
		if (i_rst_n)
		begin
			if (i_rd_check && (i_test_rd_data !== i_rd_exp))
				word_mismatch("o_test_rd_data", 32'(i_rd_exp), 32'(i_test_rd_data));
			if (i_arm)
			begin
				active     = 1'b1;
				cycles     = 0;
				test_num   = i_test_num;
				exp_cycles = i_exp_cycles;
				exp_lag    = i_exp_lag;
				exp_corr   = i_exp_corr;
				t_lo       = i_t_min;
				t_hi       = i_t_max;
			end
			else if (active)
			begin
				cycles = cycles + 1;
				if (i_done)
				begin
					if (cycles != exp_cycles)
						number_mismatch("o_done latency", exp_cycles, cycles);
					if (i_best_lag !== exp_lag)
						number_mismatch("o_best_lag", int'(exp_lag), int'(i_best_lag));
					if (i_best_corr !== exp_corr)
						word_mismatch("o_best_corr", exp_corr, i_best_corr);
					close_test();
				end
				else if (cycles > exp_cycles + DONE_SLACK)
				begin
					$display("test %0d: o_done did not arrive within %0d cycles of i_start",
						test_num, cycles);
					errors++;
					close_test();
				end
			end
			else if (i_done)
			begin
				$display("o_done pulsed at %0t while no run was in progress", $time);
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/pitch_search_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module pitch_search_tb;

	localparam int L_SUBFR     = 40;
	localparam int PIT_MAX     = 143;
	localparam int EXC_BASE    = 64;
	localparam int ADDR_W      = 8;
	localparam int MEM_DEPTH   = 1 << ADDR_W;
	localparam int EXC_ORG     = EXC_BASE + PIT_MAX;
	localparam int N_ROWS      = 8;
	localparam int LOAD_CYCLES = 2 * MEM_DEPTH + 4;
	localparam int MARGIN      = 200;
	// Second start lands late in a full range run
	localparam int RESTART_GAP = 2000;
	localparam longint Q31_MAX = 64'sd2147483647;
	localparam longint Q31_MIN = -64'sd2147483648;

	// Data patterns
	localparam int PAT_RANDOM = 0;
	localparam int PAT_RAMP   = 1;
	localparam int PAT_FULL   = 2;
	localparam int PAT_PEAK   = 3;

	// Expected lag of -1 means the reference model decides
	typedef struct packed
	{
		int   pattern;
		int   t_min;
		int   t_max;
		int   seed_off;
		int   peak_lag;
		int   exp_lag;
		logic exp_sat;
		logic restart;
	} row_t;

	row_t rows [N_ROWS];

	logic                i_clock;
	logic                i_rst_n = 1'b0;
	logic                i_start = 1'b0;
	logic                i_test_mode = 1'b0;
	pitch_pkg::mem_wr_t  i_test_wr = '0;
	logic [ADDR_W-1:0]   i_test_rd_addr = '0;
	logic [7:0]          i_t_min = 8'd20;
	logic [7:0]          i_t_max = 8'd20;
	logic [15:0]         o_test_rd_data;
	logic                o_done;
	logic [7:0]          o_best_lag;
	logic [31:0]         o_best_corr;

	logic                rd_check = 1'b0;
	logic [15:0]         rd_exp = '0;
	logic                arm = 1'b0;
	int                  test_num = 0;
	int                  exp_cycles = 0;
	logic [7:0]          exp_best_lag = '0;
	logic [31:0]         exp_best_corr = '0;
	int                  chk_finished;
	int                  chk_passed;
	int                  chk_errors;

	logic [15:0]         img [MEM_DEPTH];
	int                  seed = 91;
	int                  cycle_limit = 0;
	int                  cycle_cnt = 0;
	int                  r;

	pitch_search_top #(
		.L_SUBFR  (L_SUBFR),
		.PIT_MAX  (PIT_MAX),
		.EXC_BASE (EXC_BASE),
		.ADDR_W   (ADDR_W)
	) dut0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_start        (i_start),
		.i_test_mode    (i_test_mode),
		.i_test_wr      (i_test_wr),
		.i_test_rd_addr (i_test_rd_addr),
		.i_t_min        (i_t_min),
		.i_t_max        (i_t_max),
		.o_test_rd_data (o_test_rd_data),
		.o_done         (o_done),
		.o_best_lag     (o_best_lag),
		.o_best_corr    (o_best_corr)
	);

	pitch_search_checker chk0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_t_min        (i_t_min),
		.i_t_max        (i_t_max),
		.i_done         (o_done),
		.i_test_rd_data (o_test_rd_data),
		.i_best_lag     (o_best_lag),
		.i_best_corr    (o_best_corr),
		.i_rd_check     (rd_check),
		.i_rd_exp       (rd_exp),
		.i_arm          (arm),
		.i_test_num     (test_num),
		.i_exp_cycles   (exp_cycles),
		.i_exp_lag      (exp_best_lag),
		.i_exp_corr     (exp_best_corr),
		.o_finished     (chk_finished),
		.o_passed       (chk_passed),
		.o_errors       (chk_errors)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model with ETSI style L_mac over the subframe
	////////////////////////////////////////////////////////////////////////////

	function automatic longint lag_corr(input int lag);
		longint             acc;
		longint             prod;
		logic signed [15:0] xs;
		logic signed [15:0] es;
		int                 n;
		acc = 0;
		for (n = 0; n < L_SUBFR; n++)
		begin
			xs = img[n];
			es = img[EXC_ORG + n - lag];
			// -1 times -1 is the one product that overflows Q31
			if (xs == 16'sh8000 && es == 16'sh8000)
				prod = Q31_MAX;
			else
				prod = 2 * longint'(xs) * longint'(es);
			acc = acc + prod;
			if (acc > Q31_MAX)
				acc = Q31_MAX;
			else if (acc < Q31_MIN)
				acc = Q31_MIN;
		end
		return acc;
	endfunction

	// Strictly greater wins, so ties keep the smaller lag
	task automatic find_best_lag(input int t_min, input int t_max,
		output int best_lag, output longint best_corr);
		int     t;
		longint c;
		best_lag  = t_min;
		best_corr = lag_corr(t_min);
		for (t = t_min + 1; t <= t_max; t++)
		begin
			c = lag_corr(t);
			if (c > best_corr)
			begin
				best_lag  = t;
				best_corr = c;
			end
		end
	endtask

	function automatic int run_budget();
		int total;
		int i;
		total = MARGIN;
		for (i = 0; i < N_ROWS; i++)
			total += ((rows[i].t_max - rows[i].t_min + 2) / 2) * L_SUBFR + 4 + LOAD_CYCLES;
		return total;
	endfunction

	task automatic build_image(input row_t row);
		int a;
		int n;
		int rnd;
		seed = 91 + row.seed_off;
		for (a = 0; a < MEM_DEPTH; a++)
		begin
			rnd = $random(seed);
			case (row.pattern)
				PAT_RAMP: img[a] = 16'(a * 24 - 3072);
				PAT_FULL: img[a] = (a < L_SUBFR || a >= EXC_BASE) ? 16'h8000 : 16'(a);
				// Large x against quiet excitation
				PAT_PEAK: img[a] = (a < L_SUBFR) ? 16'(rnd >>> 20) : 16'(rnd >>> 26);
				default:  img[a] = 16'(rnd >>> 17);
			endcase
		end
		if (row.pattern == PAT_PEAK)
		begin
			for (n = 0; n < L_SUBFR; n++)
				img[EXC_ORG + n - row.peak_lag] = img[n];
		end
	endtask

	// Write every word, then read each back one cycle behind its address
	task automatic load_memory();
		int a;
		i_test_mode = 1'b1;
		for (a = 0; a < MEM_DEPTH; a++)
		begin
			i_test_wr = '{en: 1'b1, addr: 8'(a), data: img[a]};
			@(negedge i_clock);
		end
		i_test_wr = '0;
		for (a = 0; a <= MEM_DEPTH; a++)
		begin
			i_test_rd_addr = ADDR_W'(a % MEM_DEPTH);
			rd_check       = (a > 0);
			rd_exp         = img[(a + MEM_DEPTH - 1) % MEM_DEPTH];
			@(negedge i_clock);
		end
		rd_check    = 1'b0;
		i_test_mode = 1'b0;
		@(negedge i_clock);
	endtask

	task automatic run_row(input int idx);
		row_t   row;
		int     best_lag;
		longint best_corr;
		int     prev_finished;
		row = rows[idx];
		build_image(row);
		load_memory();
		find_best_lag(row.t_min, row.t_max, best_lag, best_corr);
		if (row.exp_lag >= 0)
			best_lag = row.exp_lag;
		if (row.exp_sat)
			best_corr = Q31_MAX;
		test_num      = idx;
		exp_cycles    = ((row.t_max - row.t_min + 2) / 2) * L_SUBFR + 4;
		exp_best_lag  = 8'(best_lag);
		exp_best_corr = 32'(best_corr);
		i_t_min       = 8'(row.t_min);
		i_t_max       = 8'(row.t_max);
		prev_finished = chk_finished;
		i_start       = 1'b1;
		arm           = 1'b1;
		@(negedge i_clock);
		i_start = 1'b0;
		arm     = 1'b0;
		// Second start with another range that the DUT ignores
		if (row.restart)
		begin
			repeat (RESTART_GAP) @(negedge i_clock);
			i_t_min = 8'd20;
			i_t_max = 8'd21;
			i_start = 1'b1;
			@(negedge i_clock);
			i_start = 1'b0;
			i_t_min = 8'(row.t_min);
			i_t_max = 8'(row.t_max);
		end
		while (chk_finished == prev_finished)
			@(negedge i_clock);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		rows[0] = '{PAT_RANDOM, 20, 143, 0, 0, -1, 1'b0, 1'b0};
		rows[1] = '{PAT_PEAK, 20, 143, 1, 97, 97, 1'b0, 1'b1};
		rows[2] = '{PAT_RAMP, 20, 143, 2, 0, -1, 1'b0, 1'b0};
		rows[3] = '{PAT_RANDOM, 20, 143, 3, 0, -1, 1'b0, 1'b1};
		rows[4] = '{PAT_PEAK, 60, 70, 4, 71, -1, 1'b0, 1'b0};
		rows[5] = '{PAT_RANDOM, 100, 100, 5, 0, -1, 1'b0, 1'b0};
		rows[6] = '{PAT_FULL, 35, 143, 6, 0, 35, 1'b1, 1'b0};
		rows[7] = '{PAT_PEAK, 120, 143, 7, 143, 143, 1'b0, 1'b0};
		cycle_limit = run_budget();
		repeat (8) @(negedge i_clock);
		i_rst_n = 1'b1;
		@(negedge i_clock);
		for (r = 0; r < N_ROWS; r++)
			run_row(r);
		@(negedge i_clock);
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			chk_finished, chk_passed, chk_finished - chk_passed, chk_errors);
		if (chk_errors == 0 && chk_finished == N_ROWS)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Cycle budget for the whole table
	initial
	begin
		wait (i_rst_n === 1'b1);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge i_clock);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles without finishing all tests", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
common/pitch_pkg.sv
verilog/scratch_mem.sv
lag_search/lag_search_ctrl.sv
lag_search/corr_lane.sv
lag_search/lag_select.sv
verilog/pitch_search_top.sv
tests/pitch_search_checker.sv
tests/pitch_search_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pitch search testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing --assert -Wno-fatal \
	--top-module pitch_search_tb \
	-f flist.f \
	--Mdir "${BUILD_DIR}" \
	-o pitch_search_sim

"./${BUILD_DIR}/pitch_search_sim" | tee "${LOG_FILE}"

if grep -q "^NO ERRORS$" "${LOG_FILE}"; then
	echo "simulation passed"
else
	echo "simulation failed, see ${LOG_FILE}"
	exit 1
fi
